// ==== verilog/amul_pkg.sv ====
package amul_pkg;

    localparam int WORD_W = 16;

    typedef logic signed [WORD_W-1:0]   operand_t;
    typedef logic signed [2*WORD_W-1:0] product_t;
    typedef logic signed [2*WORD_W-1:0] error_t;
    typedef logic [2*WORD_W-1:0]        axil_data_t;

    typedef struct packed {
        logic     valid;
        operand_t x;
        operand_t y;
    } mul_req_t;

    typedef struct packed {
        logic     valid;
        product_t product;
    } mul_res_t;

    typedef struct packed {
        product_t   last_approx;
        product_t   last_exact;
        error_t     last_error;
        axil_data_t err_sum;
        axil_data_t err_max;
        axil_data_t count;
    } stats_t;

    // byte offsets of the register map
    localparam axil_data_t REG_OPERANDS = 32'h00;
    localparam axil_data_t REG_STATUS   = 32'h04;
    localparam axil_data_t REG_APPROX   = 32'h08;
    localparam axil_data_t REG_EXACT    = 32'h0C;
    localparam axil_data_t REG_ERROR    = 32'h10;
    localparam axil_data_t REG_ERR_SUM  = 32'h14;
    localparam axil_data_t REG_ERR_MAX  = 32'h18;
    localparam axil_data_t REG_COUNT    = 32'h1C;
    localparam axil_data_t REG_CLEAR    = 32'h20;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_HAVE_ADDR,
        WR_HAVE_DATA,
        WR_RESP
    } axil_wr_state_t;

endpackage

// ==== verilog/amul_axil_regs.sv ====
module amul_axil_regs #(
    parameter int ADDR_W = 6
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [ADDR_W-1:0]    awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  amul_pkg::axil_data_t wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [ADDR_W-1:0]    araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output amul_pkg::axil_data_t rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    output amul_pkg::mul_req_t   req,
    output logic                 clear,
    input  amul_pkg::stats_t     stats
);

    amul_pkg::axil_wr_state_t wr_state, wr_state_d;

    logic [ADDR_W-1:0]    addr_q, addr_eff;
    amul_pkg::axil_data_t data_q, data_eff;
    logic [3:0]           strb_q, strb_eff;
    logic                 aw_hs, w_hs, ar_hs;
    logic                 wr_fire, wr_ok, wr_op, wr_clr, launch;
    logic                 req_valid, pipe_q, busy;
    logic [1:0]           inflight;
    amul_pkg::operand_t   op_x, op_y;
    amul_pkg::axil_data_t rd_data;
    logic                 rd_ok;

    assign awready = (wr_state == amul_pkg::WR_IDLE) || (wr_state == amul_pkg::WR_HAVE_DATA);
    assign wready  = (wr_state == amul_pkg::WR_IDLE) || (wr_state == amul_pkg::WR_HAVE_ADDR);
    assign bvalid  = (wr_state == amul_pkg::WR_RESP);
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    // whichever half arrived earlier comes from its latch
    assign addr_eff = (wr_state == amul_pkg::WR_HAVE_ADDR) ? addr_q : awaddr;
    assign data_eff = (wr_state == amul_pkg::WR_HAVE_DATA) ? data_q : wdata;
    assign strb_eff = (wr_state == amul_pkg::WR_HAVE_DATA) ? strb_q : wstrb;

    always_comb begin
        wr_state_d = wr_state;
        unique case (wr_state)
            amul_pkg::WR_IDLE: begin
                if (aw_hs && w_hs) begin
                    wr_state_d = amul_pkg::WR_RESP;
                end else if (aw_hs) begin
                    wr_state_d = amul_pkg::WR_HAVE_ADDR;
                end else if (w_hs) begin
                    wr_state_d = amul_pkg::WR_HAVE_DATA;
                end
            end
            amul_pkg::WR_HAVE_ADDR: if (w_hs) wr_state_d = amul_pkg::WR_RESP;
            amul_pkg::WR_HAVE_DATA: if (aw_hs) wr_state_d = amul_pkg::WR_RESP;
            amul_pkg::WR_RESP:      if (bready) wr_state_d = amul_pkg::WR_IDLE;
            default:                wr_state_d = amul_pkg::WR_IDLE;
        endcase
    end

    assign wr_fire = (wr_state != amul_pkg::WR_RESP) && (wr_state_d == amul_pkg::WR_RESP);

    // write decode, read-only and unmapped offsets fall to the default
    always_comb begin
        wr_ok  = 1'b0;
        wr_op  = 1'b0;
        wr_clr = 1'b0;
        case (amul_pkg::axil_data_t'(addr_eff))
            amul_pkg::REG_OPERANDS: begin
                wr_ok = &strb_eff;
                wr_op = &strb_eff;
            end
            amul_pkg::REG_CLEAR: begin
                wr_ok  = 1'b1;
                wr_clr = 1'b1;
            end
            default: ;
        endcase
    end

    assign launch = wr_fire && wr_op;

    always_ff @(posedge clk) begin
        if (aw_hs) addr_q <= awaddr;
        if (w_hs) begin
            data_q <= wdata;
            strb_q <= wstrb;
        end
        if (launch) begin
            op_x <= data_eff[15:0];
            op_y <= data_eff[31:16];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state  <= amul_pkg::WR_IDLE;
            bresp     <= amul_pkg::RESP_OKAY;
            req_valid <= 1'b0;
            clear     <= 1'b0;
            pipe_q    <= 1'b0;
            inflight  <= '0;
        end else begin
            wr_state  <= wr_state_d;
            req_valid <= launch;
            clear     <= wr_fire && wr_clr;
            pipe_q    <= req_valid;
            if (wr_fire) bresp <= wr_ok ? amul_pkg::RESP_OKAY : amul_pkg::RESP_SLVERR;
            // a sample leaves once its multiplier results are on the stats input
            case ({launch, pipe_q})
                2'b10:   inflight <= inflight + 2'd1;
                2'b01:   inflight <= inflight - 2'd1;
                default: ;
            endcase
        end
    end

    assign busy = (inflight != 2'd0);
    assign req  = '{valid: req_valid, x: op_x, y: op_y};

    assign arready = !rvalid;
    assign ar_hs   = arvalid && arready;

    always_comb begin
        rd_ok   = 1'b1;
        rd_data = '0;
        case (amul_pkg::axil_data_t'(araddr))
            amul_pkg::REG_OPERANDS: rd_data = {op_y, op_x};
            amul_pkg::REG_STATUS:   rd_data = {31'd0, busy};
            amul_pkg::REG_APPROX:   rd_data = stats.last_approx;
            amul_pkg::REG_EXACT:    rd_data = stats.last_exact;
            amul_pkg::REG_ERROR:    rd_data = stats.last_error;
            amul_pkg::REG_ERR_SUM:  rd_data = stats.err_sum;
            amul_pkg::REG_ERR_MAX:  rd_data = stats.err_max;
            amul_pkg::REG_COUNT:    rd_data = stats.count;
            amul_pkg::REG_CLEAR:    rd_data = '0;
            default:                rd_ok   = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_data;
            rresp <= rd_ok ? amul_pkg::RESP_OKAY : amul_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (ar_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

// ==== verilog/approx_mul_bw16.sv ====
module approx_mul_bw16 (
    input  logic               clk,
    input  logic               arst_n,
    input  amul_pkg::mul_req_t req,
    output amul_pkg::mul_res_t res
);

    logic [15:0]        pp [1:16];
    logic [20:0]        np1, np2, np3, np4;
    amul_pkg::product_t sum;
    amul_pkg::product_t res_product;
    logic               res_valid;

    // baugh-wooley rows, row k is weighted by x[k-1]
    always_comb begin
        for (int k = 1; k <= 15; k++) begin
            pp[k][14:0] = req.y[14:0] & {15{req.x[k-1]}};
            pp[k][15]   = ~(req.y[15] & req.x[k-1]);
        end
        pp[16][14:0] = ~(req.y[14:0] & {15{req.x[15]}});
        pp[16][15]   = req.y[15] & req.x[15];
    end

    // sparse stand-in for rows 1 to 6
    always_comb begin
        np1 = '0;
        np2 = '0;
        np3 = '0;
        np4 = '0;

        np1[3]  = pp[3][1] ^ pp[4][0];
        np1[6]  = pp[1][6] ^ pp[2][5];
        np1[9]  = pp[1][8] & pp[2][7];
        np1[10] = pp[1][10] ^ pp[2][9];
        np1[11] = pp[3][8] & pp[4][7];
        np1[13] = pp[1][12] & pp[2][11];
        np1[15] = pp[1][14] & pp[2][13];
        np1[16] = pp[1][15] & pp[2][14];
        np1[17] = pp[2][15];
        np1[18] = pp[3][15] & pp[4][14];
        np1[19] = pp[5][14] & pp[6][13];
        np1[20] = pp[5][15] & pp[6][14];

        np2[6]  = pp[3][4] ^ pp[4][3];
        np2[10] = pp[5][5] & pp[6][4];
        np2[15] = pp[5][11] ^ pp[6][10];
        np2[16] = pp[3][13] & pp[4][12];
        np2[17] = ~pp[2][15];
        np2[18] = pp[4][15];
        np2[19] = pp[5][15] ^ pp[6][14];
        np2[20] = pp[6][15];

        np3[6]  = pp[5][2] ^ pp[6][1];
        np3[16] = pp[3][14] ^ pp[4][13];
        np3[17] = pp[3][14] | pp[4][13];
        np3[18] = pp[5][14] & pp[6][13];

        np4[16] = pp[5][12] ^ pp[6][11];
        np4[17] = pp[3][15] ^ pp[4][14];
        np4[18] = pp[5][14] ^ pp[6][13];
    end

    always_comb begin
        sum = 32'sh8000_0000;
        for (int k = 7; k <= 16; k++) begin
            sum = sum + (amul_pkg::product_t'(pp[k]) << (k - 1));
        end
        sum = sum + amul_pkg::product_t'(np1) + amul_pkg::product_t'(np2);
        sum = sum + amul_pkg::product_t'(np3) + amul_pkg::product_t'(np4);
    end

    always_ff @(posedge clk) begin
        if (req.valid) res_product <= sum;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req.valid;
        end
    end

    assign res = '{valid: res_valid, product: res_product};

endmodule

// ==== verilog/exact_mul_bw16.sv ====
module exact_mul_bw16 (
    input  logic               clk,
    input  logic               arst_n,
    input  amul_pkg::mul_req_t req,
    output amul_pkg::mul_res_t res
);

    logic [15:0]        pp [1:16];
    amul_pkg::product_t sum;
    amul_pkg::product_t res_product;
    logic               res_valid;

    for (genvar k = 1; k <= 16; k++) begin : g_row
        if (k < 16) begin : g_plain
            assign pp[k][14:0] = req.y[14:0] & {15{req.x[k-1]}};
            assign pp[k][15]   = ~(req.y[15] & req.x[k-1]);
        end else begin : g_sign
            assign pp[k][14:0] = ~(req.y[14:0] & {15{req.x[15]}});
            assign pp[k][15]   = req.y[15] & req.x[15];
        end
    end

    // constant ones at bit 16 of the first and last rows
    always_comb begin
        sum = 32'sh8001_0000;
        for (int k = 1; k <= 16; k++) begin
            sum = sum + (amul_pkg::product_t'(pp[k]) << (k - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) res_product <= sum;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req.valid;
        end
    end

    assign res = '{valid: res_valid, product: res_product};

endmodule

// ==== verilog/mul_error_stats.sv ====
module mul_error_stats #(
    parameter int SUM_W = 32
) (
    input  logic               clk,
    input  logic               arst_n,
    input  amul_pkg::mul_res_t approx,
    input  amul_pkg::mul_res_t exact,
    input  logic               clear,
    output amul_pkg::stats_t   stats
);

    localparam logic [32:0] SUM_MAX = (33'd1 << SUM_W) - 33'd1;

    amul_pkg::product_t   last_approx, last_exact;
    amul_pkg::error_t     last_error, err;
    amul_pkg::axil_data_t abs_err, err_max, count;
    logic [SUM_W-1:0]     err_sum;
    logic [32:0]          sum_wide;
    logic                 sample;

    assign sample   = approx.valid && exact.valid;
    assign err      = approx.product - exact.product;
    assign abs_err  = err[31] ? amul_pkg::axil_data_t'(-err) : amul_pkg::axil_data_t'(err);
    assign sum_wide = 33'(err_sum) + 33'(abs_err);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_approx <= '0;
            last_exact  <= '0;
            last_error  <= '0;
            err_sum     <= '0;
            err_max     <= '0;
            count       <= '0;
        end else if (clear) begin
            last_approx <= '0;
            last_exact  <= '0;
            last_error  <= '0;
            err_sum     <= '0;
            err_max     <= '0;
            count       <= '0;
        end else if (sample) begin
            last_approx <= approx.product;
            last_exact  <= exact.product;
            last_error  <= err;
            // sticks at all ones once the accumulator overflows
            err_sum     <= (sum_wide > SUM_MAX) ? SUM_MAX[SUM_W-1:0] : sum_wide[SUM_W-1:0];
            if (abs_err > err_max) err_max <= abs_err;
            count       <= count + 32'd1;
        end
    end

    assign stats = '{
        last_approx: last_approx,
        last_exact:  last_exact,
        last_error:  last_error,
        err_sum:     amul_pkg::axil_data_t'(err_sum),
        err_max:     err_max,
        count:       count
    };

endmodule

// ==== verilog/amul_eval_top.sv ====
module amul_eval_top #(
    parameter int ADDR_W = 6,
    parameter int SUM_W  = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [ADDR_W-1:0]    awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  amul_pkg::axil_data_t wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [ADDR_W-1:0]    araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output amul_pkg::axil_data_t rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    amul_pkg::mul_req_t req;
    amul_pkg::mul_res_t approx_res;
    amul_pkg::mul_res_t exact_res;
    amul_pkg::stats_t   stats;
    logic               clear;

    amul_axil_regs #(
        .ADDR_W(ADDR_W)
    ) u_regs (
        .clk(clk),
        .arst_n(arst_n),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .req(req),
        .clear(clear),
        .stats(stats)
    );

    // both multipliers see the same operand pair
    approx_mul_bw16 u_approx (
        .clk(clk),
        .arst_n(arst_n),
        .req(req),
        .res(approx_res)
    );

    exact_mul_bw16 u_exact (
        .clk(clk),
        .arst_n(arst_n),
        .req(req),
        .res(exact_res)
    );

    mul_error_stats #(
        .SUM_W(SUM_W)
    ) u_stats (
        .clk(clk),
        .arst_n(arst_n),
        .approx(approx_res),
        .exact(exact_res),
        .clear(clear),
        .stats(stats)
    );

endmodule

// ==== tests/amul_checker.sv ====
module amul_checker #(
    parameter int ADDR_W = 6,
    parameter int SUM_W  = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    input  logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    input  logic              wready,
    input  logic [1:0]        bresp,
    input  logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    input  logic              arready,
    input  logic [31:0]       rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    input  logic              rready,
    output int                value_errors,
    output int                proto_errors,
    output int                checks
);

    localparam logic [32:0] SUM_LIMIT = (33'd1 << SUM_W) - 33'd1;

    logic [31:0] m_op, m_approx, m_exact, m_error, m_sum, m_max, m_count;
    logic [31:0] wa, wd, ra, exp_rdata;
    logic [3:0]  ws;
    logic [1:0]  exp_bresp, exp_rresp;
    logic        have_a, have_d, b_open, r_open;
    logic        busy_exp;
    int          busy_left;
    int          n_value = 0;
    int          n_proto = 0;
    int          n_checks = 0;

    assign value_errors = n_value;
    assign proto_errors = n_proto;
    assign checks       = n_checks;

    function automatic logic [31:0] weigh(input logic b, input int col);
        return 32'(b) << col;
    endfunction

    // row k is y gated by x[k-1]; the last row has its low bits inverted, the others bit 15
    function automatic logic [15:0] bw_row(input logic [15:0] x, input logic [15:0] y,
                                          input int k);
        logic [15:0] row;
        row = y & {16{x[k-1]}};
        return (k == 16) ? row ^ 16'h7fff : row ^ 16'h8000;
    endfunction

    function automatic logic [31:0] approx_model(input logic [15:0] x, input logic [15:0] y);
        logic [15:0] r [1:16];
        logic [31:0] acc;
        for (int k = 1; k <= 16; k++) begin
            r[k] = bw_row(x, y, k);
        end
        // only the last row's constant one survives at bit 31
        acc = 32'h8000_0000;
        for (int k = 7; k <= 16; k++) begin
            acc = acc + ({16'd0, r[k]} << (k - 1));
        end
        // correction terms for rows 1 to 6 in column order
        acc = acc + weigh(r[3][1] ^ r[4][0], 3);
        acc = acc + weigh(r[1][6] ^ r[2][5], 6) + weigh(r[3][4] ^ r[4][3], 6);
        acc = acc + weigh(r[5][2] ^ r[6][1], 6) + weigh(r[1][8] & r[2][7], 9);
        acc = acc + weigh(r[1][10] ^ r[2][9], 10) + weigh(r[5][5] & r[6][4], 10);
        acc = acc + weigh(r[3][8] & r[4][7], 11) + weigh(r[1][12] & r[2][11], 13);
        acc = acc + weigh(r[1][14] & r[2][13], 15) + weigh(r[5][11] ^ r[6][10], 15);
        acc = acc + weigh(r[1][15] & r[2][14], 16) + weigh(r[3][13] & r[4][12], 16);
        acc = acc + weigh(r[3][14] ^ r[4][13], 16) + weigh(r[5][12] ^ r[6][11], 16);
        // row 2 bit 15 and its complement always add up to a one
        acc = acc + weigh(1'b1, 17) + weigh(r[3][14] | r[4][13], 17);
        acc = acc + weigh(r[3][15] ^ r[4][14], 17);
        acc = acc + weigh(r[3][15] & r[4][14], 18) + weigh(r[4][15], 18);
        acc = acc + weigh(r[5][14] & r[6][13], 18) + weigh(r[5][14] ^ r[6][13], 18);
        acc = acc + weigh(r[5][14] & r[6][13], 19) + weigh(r[5][15] ^ r[6][14], 19);
        acc = acc + weigh(r[5][15] & r[6][14], 20) + weigh(r[6][15], 20);
        return acc;
    endfunction

    function automatic string reg_name(input logic [31:0] a);
        case (a)
            amul_pkg::REG_OPERANDS: return "REG_OPERANDS";
            amul_pkg::REG_STATUS:   return "REG_STATUS";
            amul_pkg::REG_APPROX:   return "REG_APPROX";
            amul_pkg::REG_EXACT:    return "REG_EXACT";
            amul_pkg::REG_ERROR:    return "REG_ERROR";
            amul_pkg::REG_ERR_SUM:  return "REG_ERR_SUM";
            amul_pkg::REG_ERR_MAX:  return "REG_ERR_MAX";
            amul_pkg::REG_COUNT:    return "REG_COUNT";
            default:                return "rdata";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            n_value = n_value + 1;
            $display("ERROR %s expected 0x%08h got 0x%08h", name, exp, got);
        end
    endtask

    task automatic clear_stats();
        m_approx = '0;
        m_exact  = '0;
        m_error  = '0;
        m_sum    = '0;
        m_max    = '0;
        m_count  = '0;
    endtask

    task automatic take_sample(input logic [31:0] pair);
        logic [31:0] ab;
        logic [32:0] wide;
        m_op     = pair;
        m_exact  = 32'($signed(pair[15:0])) * 32'($signed(pair[31:16]));
        m_approx = approx_model(pair[15:0], pair[31:16]);
        m_error  = m_approx - m_exact;
        ab       = m_error[31] ? -m_error : m_error;
        wide     = {1'b0, m_sum} + {1'b0, ab};
        m_sum    = (wide > SUM_LIMIT) ? SUM_LIMIT[31:0] : wide[31:0];
        if (ab > m_max) m_max = ab;
        m_count  = m_count + 32'd1;
    endtask

    task automatic expect_read(input logic [31:0] a);
        exp_rresp = amul_pkg::RESP_OKAY;
        exp_rdata = '0;
        case (a)
            amul_pkg::REG_OPERANDS: exp_rdata = m_op;
            amul_pkg::REG_STATUS:   exp_rdata = {31'd0, busy_exp};
            amul_pkg::REG_APPROX:   exp_rdata = m_approx;
            amul_pkg::REG_EXACT:    exp_rdata = m_exact;
            amul_pkg::REG_ERROR:    exp_rdata = m_error;
            amul_pkg::REG_ERR_SUM:  exp_rdata = m_sum;
            amul_pkg::REG_ERR_MAX:  exp_rdata = m_max;
            amul_pkg::REG_COUNT:    exp_rdata = m_count;
            amul_pkg::REG_CLEAR: ;
            default:                exp_rresp = amul_pkg::RESP_SLVERR;
        endcase
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            have_a    = 1'b0;
            have_d    = 1'b0;
            b_open    = 1'b0;
            r_open    = 1'b0;
            busy_exp  = 1'b0;
            busy_left = 0;
            m_op      = '0;
            clear_stats();
        end else begin
            // a sample is busy in its request cycle and its multiplier cycle
            busy_exp = (busy_left > 0);
            if (busy_left > 0) busy_left = busy_left - 1;
            if (bvalid && (awready || wready)) begin
                n_proto = n_proto + 1;
                $display("a write channel was ready while a write response was pending");
            end
            if (rvalid && arready) begin
                n_proto = n_proto + 1;
                $display("the read address channel was ready while read data was pending");
            end
            // held read data must keep its value until rready
            if (rvalid) begin
                if (!r_open) begin
                    n_proto = n_proto + 1;
                    $display("read data was presented without an accepted read address");
                end else begin
                    check_value(reg_name(ra), exp_rdata, rdata);
                end
                check_value("rresp", 32'(exp_rresp), 32'(rresp));
                if (rready) begin
                    r_open   = 1'b0;
                    n_checks = n_checks + 1;
                end
            end else if (r_open) begin
                n_proto = n_proto + 1;
                $display("read data was not presented and held until rready");
                r_open = 1'b0;
            end
            if (arvalid && arready) begin
                ra = 32'(araddr);
                expect_read(ra);
                r_open = 1'b1;
            end
            if (bvalid) begin
                if (!b_open) begin
                    n_proto = n_proto + 1;
                    $display("write response was raised without a completed write");
                end else begin
                    check_value("bresp", 32'(exp_bresp), 32'(bresp));
                end
                if (bready) begin
                    b_open   = 1'b0;
                    n_checks = n_checks + 1;
                end
            end else if (b_open) begin
                n_proto = n_proto + 1;
                $display("write response was not raised and held until bready");
                b_open = 1'b0;
            end
            if (awvalid && awready) begin
                wa     = 32'(awaddr);
                have_a = 1'b1;
            end
            if (wvalid && wready) begin
                wd     = wdata;
                ws     = wstrb;
                have_d = 1'b1;
            end
            if (have_a && have_d) begin
                exp_bresp = amul_pkg::RESP_SLVERR;
                if (wa == amul_pkg::REG_OPERANDS && ws == 4'hf) begin
                    exp_bresp = amul_pkg::RESP_OKAY;
                    take_sample(wd);
                    busy_left = 2;
                end else if (wa == amul_pkg::REG_CLEAR) begin
                    exp_bresp = amul_pkg::RESP_OKAY;
                    clear_stats();
                end
                have_a = 1'b0;
                have_d = 1'b0;
                b_open = 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_amul_eval.sv ====
module tb_amul_eval;

    localparam int ADDR_W = 6;
    localparam int SUM_W  = 32;
    localparam int PERIOD = 40;
    localparam int N_EDGE = 8;
    localparam int N_VEC  = 24;

    // {y, x} pairs: -32768 squared, zeros, -1 squared, and the range corners
    localparam logic [31:0] EDGE_PAIRS [N_EDGE] = '{
        32'h8000_8000, 32'h0000_0000, 32'hffff_ffff, 32'h7fff_7fff,
        32'h7fff_8000, 32'h0001_ffff, 32'h1234_0000, 32'h8000_ffff
    };
    localparam logic [31:0] RESULT_REGS [7] = '{
        amul_pkg::REG_APPROX, amul_pkg::REG_EXACT, amul_pkg::REG_ERROR,
        amul_pkg::REG_ERR_SUM, amul_pkg::REG_ERR_MAX, amul_pkg::REG_COUNT,
        amul_pkg::REG_OPERANDS
    };
    localparam logic [ADDR_W-1:0] A_OPS    = ADDR_W'(amul_pkg::REG_OPERANDS);
    localparam logic [ADDR_W-1:0] A_STATUS = ADDR_W'(amul_pkg::REG_STATUS);
    localparam logic [ADDR_W-1:0] A_CLEAR  = ADDR_W'(amul_pkg::REG_CLEAR);

    logic              clk;
    logic              arst_n;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [31:0]       wdata, rdata;
    logic [3:0]        wstrb;
    logic [1:0]        bresp, rresp;
    logic [31:0]       pairs [N_VEC];
    int                seed = 32'h8a87_fa75;
    int                value_errors, proto_errors, checks;

    amul_eval_top #(.ADDR_W(ADDR_W), .SUM_W(SUM_W)) UUT (.*);

    amul_checker #(.ADDR_W(ADDR_W), .SUM_W(SUM_W)) u_check (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(N_VEC * 40 * PERIOD);
        $display("timeout: the register tests did not complete in time");
        $display("=== FAIL ===");
        $finish;
    end

    // order 0 sends both channels together, 1 address first, 2 data first
    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int order, input int hold);
        logic a_done, d_done;
        a_done = 1'b0;
        d_done = 1'b0;
        if (order != 2) begin
            awaddr  = addr;
            awvalid = 1'b1;
        end
        if (order != 1) begin
            wdata  = data;
            wstrb  = strb;
            wvalid = 1'b1;
        end
        while (!(a_done && d_done)) begin
            @(posedge clk);
            if (awvalid && awready) a_done = 1'b1;
            if (wvalid && wready) d_done = 1'b1;
            #2;
            if (a_done) awvalid = 1'b0;
            if (d_done) wvalid = 1'b0;
            if (a_done && !d_done && !wvalid) begin
                wdata  = data;
                wstrb  = strb;
                wvalid = 1'b1;
            end
            if (d_done && !a_done && !awvalid) begin
                awaddr  = addr;
                awvalid = 1'b1;
            end
        end
        while (!bvalid) begin
            @(posedge clk);
            #2;
        end
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, input int hold,
                             output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(posedge clk);
        end while (!arready);
        #2;
        arvalid = 1'b0;
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        @(posedge clk);
        data = rdata;
        #2;
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'd1;
        while (st[0]) begin
            axil_read(A_STATUS, 0, st);
        end
    endtask

    task automatic read_results(input int hold);
        logic [31:0] d;
        for (int j = 0; j < 7; j++) begin
            axil_read(ADDR_W'(RESULT_REGS[j]), (j == 3) ? hold : 0, d);
        end
    endtask

    initial begin
        logic [31:0] d;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < N_VEC; i++) begin
            pairs[i] = (i < N_EDGE) ? EDGE_PAIRS[i] : $random(seed);
        end
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int i = 0; i < N_VEC; i++) begin
            axil_write(A_OPS, pairs[i], 4'hf, i % 3, (i % 4 == 3) ? 3 : 0);
            wait_idle();
            read_results((i % 5 == 4) ? 3 : 0);
            if (i == N_VEC / 2) begin
                axil_write(A_CLEAR, 32'h1, 4'hf, 0, 0);
                wait_idle();
                read_results(0);
            end
        end

        // rejected writes must leave every register as it was
        axil_write(ADDR_W'(amul_pkg::REG_APPROX), 32'hdead_beef, 4'hf, 0, 0);
        axil_write(A_STATUS, 32'h1, 4'hf, 1, 0);
        axil_write(ADDR_W'(32'h24), 32'h5555_aaaa, 4'hf, 2, 0);
        axil_write(ADDR_W'(32'h02), 32'h0007_0009, 4'hf, 0, 0);
        axil_write(A_OPS, 32'h0003_0005, 4'h7, 0, 2);
        wait_idle();
        read_results(0);
        axil_read(ADDR_W'(32'h3c), 2, d);

        // several samples in flight at once
        for (int i = 0; i < 3; i++) begin
            axil_write(A_OPS, pairs[N_VEC - 1 - i] ^ 32'h00ff_ff00, 4'hf, 0, 0);
        end
        wait_idle();
        read_results(0);

        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0 && checks > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/amul_pkg.sv
verilog/amul_axil_regs.sv
verilog/approx_mul_bw16.sv
verilog/exact_mul_bw16.sv
verilog/mul_error_stats.sv
verilog/amul_eval_top.sv
tests/amul_checker.sv
tests/tb_amul_eval.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_amul_eval -o tb_amul_eval
./obj_dir/tb_amul_eval | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
